/* all.f */
+incdir+source
source/tile_map_pkg.sv
source/tile_msg_pkg.sv
source/l2e_ctrl.sv
source/cfg_regs.sv
source/l2_slice.sv
source/wb_mem_master.sv
source/l2e_tile.sv
tb/l2e_tile_props.sv
tb/l2e_tile_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the tile testbench with Verilator, run it and scan the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f all.f --top-module l2e_tile_tb -o l2e_tile_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/l2e_tile_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
  exit 1
fi
exit 0

/* source/cfg_regs.sv */
`include "tile_cfg.svh"

module cfg_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  tile_msg_pkg::mem_cmd_s   cmd_i,
  input  logic                     cmd_valid_i,
  input  logic [`TILE_DID_W-1:0]   my_did_i,
  output logic                     resp_valid_o,
  output logic [`TILE_DATA_W-1:0]  resp_data_o,
  input  logic                     resp_yumi_i
);

  logic [`TILE_DATA_W-1:0]     regs_r [1:`TILE_CFG_REGS-1];
  logic [`TILE_CFG_IDX_W-1:0]  idx;
  logic [`TILE_DATA_W-1:0]     rd_data;
  logic                        resp_valid_r;
  logic [`TILE_DATA_W-1:0]     resp_data_r;

  assign idx     = cmd_i.addr.cfg.reg_idx;
  assign rd_data = (idx == '0) ? `TILE_DATA_W'(my_did_i) : regs_r[idx]; // Register 0 is the id.

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_r <= 1'b0;
      for (int i = 1; i < `TILE_CFG_REGS; i++) begin
        regs_r[i] <= '0;
      end
    end else begin
      if (cmd_valid_i) begin
        resp_valid_r <= 1'b1;
      end else if (resp_yumi_i) begin
        resp_valid_r <= 1'b0;
      end
      if (cmd_valid_i && cmd_i.we && (idx != '0)) begin
        regs_r[idx] <= cmd_i.data;
      end
    end
  end

  // Write acks carry the old contents.
  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      resp_data_r <= rd_data;
    end
  end

  assign resp_valid_o = resp_valid_r;
  assign resp_data_o  = resp_data_r;

endmodule

/* source/l2_slice.sv */
`include "tile_cfg.svh"

module l2_slice (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  input  tile_msg_pkg::mem_cmd_s   cmd_i,
  input  logic                     cmd_valid_i,

  output logic                     resp_valid_o,
  output logic [`TILE_DATA_W-1:0]  resp_data_o,
  input  logic                     resp_yumi_i,

  output logic                     bus_req_o,
  output logic                     bus_we_o,
  output logic [`TILE_ADDR_W-1:0]  bus_adr_o,
  output logic [`TILE_DATA_W-1:0]  bus_dat_o,
  input  logic                     bus_done_i,
  input  logic [`TILE_DATA_W-1:0]  bus_rdata_i
);

  typedef enum logic [1:0] {s_idle, s_bus, s_resp} state_e;

  state_e                     state_r;
  tile_msg_pkg::mem_cmd_s     cmd_r;
  logic [`TILE_L2_SETS-1:0]   valid_r;
  logic [`TILE_L2_TAG_W-1:0]  tag_r  [`TILE_L2_SETS];
  logic [`TILE_DATA_W-1:0]    data_r [`TILE_L2_SETS];
  logic                       bus_req_r;
  logic [`TILE_DATA_W-1:0]    resp_data_r;
  tile_map_pkg::l2_addr_s     in_addr, held_addr;
  logic                       hit, rd_hit, go_bus, fill;

  assign in_addr   = cmd_i.addr.l2;
  assign held_addr = cmd_r.addr.l2;

  assign hit    = valid_r[in_addr.idx] && (tag_r[in_addr.idx] == in_addr.tag);
  assign rd_hit = cmd_valid_i && !cmd_i.we && hit;
  assign go_bus = cmd_valid_i && !rd_hit;          // Misses and all writes.
  assign fill   = (state_r == s_bus) && bus_done_i && !cmd_r.we;

  // ****************************************
  // Control
  // ****************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r   <= s_idle;
      bus_req_r <= 1'b0;
      valid_r   <= '0;
    end else begin
      bus_req_r <= go_bus;
      case (state_r)
        s_idle: begin
          if (rd_hit) state_r <= s_resp;
          else if (go_bus) state_r <= s_bus;
        end
        s_bus:   if (bus_done_i) state_r <= s_resp;
        s_resp:  if (resp_yumi_i) state_r <= s_idle;
        default: state_r <= s_idle;
      endcase
      if (fill) begin
        valid_r[held_addr.idx] <= 1'b1;
      end
    end
  end

  // ****************************************
  // Arrays and payload
  // ****************************************
  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      cmd_r <= cmd_i;
    end
    if (fill) begin
      tag_r[held_addr.idx]  <= held_addr.tag;
      data_r[held_addr.idx] <= bus_rdata_i;
    end else if (cmd_valid_i && cmd_i.we && hit) begin
      data_r[in_addr.idx] <= cmd_i.data; // No allocate on a write miss.
    end
    if (rd_hit) begin
      resp_data_r <= data_r[in_addr.idx];
    end else if ((state_r == s_bus) && bus_done_i) begin
      resp_data_r <= cmd_r.we ? cmd_r.data : bus_rdata_i;
    end
  end

  assign resp_valid_o = (state_r == s_resp);
  assign resp_data_o  = resp_data_r;

  assign bus_req_o = bus_req_r;
  assign bus_we_o  = cmd_r.we;
  assign bus_adr_o = cmd_r.addr;
  assign bus_dat_o = cmd_r.data;

endmodule

/* source/l2e_ctrl.sv */
`include "tile_cfg.svh"

module l2e_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  input  tile_msg_pkg::lce_req_s   req_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,

  output tile_msg_pkg::lce_rep_s   rep_o,
  output logic                     rep_valid_o,
  input  logic                     rep_ready_i,

  output tile_msg_pkg::mem_cmd_s   cmd_o,
  output logic                     cfg_cmd_valid_o,
  output logic                     l2_cmd_valid_o,

  input  logic                     cfg_resp_valid_i,
  input  logic [`TILE_DATA_W-1:0]  cfg_resp_data_i,
  output logic                     cfg_resp_yumi_o,

  input  logic                     l2_resp_valid_i,
  input  logic [`TILE_DATA_W-1:0]  l2_resp_data_i,
  output logic                     l2_resp_yumi_o
);

  typedef enum logic [1:0] {s_idle, s_issue, s_wait, s_reply} state_e;

  state_e                   state_r, state_n;
  tile_msg_pkg::lce_req_s   req_r;
  tile_msg_pkg::lce_rep_s   rep_r;
  tile_map_pkg::dest_e      dest_r, req_dest;
  tile_map_pkg::mem_addr_u  req_addr;
  tile_msg_pkg::rep_op_e    ok_op;
  logic                     req_fire, resp_fire;
  logic [`TILE_DATA_W-1:0]  resp_data;

  assign req_addr = req_i.addr;

  // ****************************************
  // Local memory map decode
  // ****************************************
  always_comb begin
    if (req_i.addr >= `TILE_DRAM_BASE) begin
      req_dest = tile_map_pkg::e_dest_l2;
    end else if (req_addr.cfg.dev == tile_map_pkg::e_dev_cfg) begin
      req_dest = tile_map_pkg::e_dest_cfg;
    end else begin
      req_dest = tile_map_pkg::e_dest_err;
    end
  end

  assign req_ready_o = (state_r == s_idle);
  assign req_fire    = req_ready_o && req_valid_i;

  assign cfg_cmd_valid_o = (state_r == s_issue) && (dest_r == tile_map_pkg::e_dest_cfg);
  assign l2_cmd_valid_o  = (state_r == s_issue) && (dest_r == tile_map_pkg::e_dest_l2);

  assign cfg_resp_yumi_o = (state_r == s_wait) && (dest_r == tile_map_pkg::e_dest_cfg)
                           && cfg_resp_valid_i;
  assign l2_resp_yumi_o  = (state_r == s_wait) && (dest_r == tile_map_pkg::e_dest_l2)
                           && l2_resp_valid_i;
  assign resp_fire = cfg_resp_yumi_o || l2_resp_yumi_o;
  assign resp_data = cfg_resp_yumi_o ? cfg_resp_data_i : l2_resp_data_i;

  assign ok_op = (req_r.op == tile_msg_pkg::e_req_wr) ? tile_msg_pkg::e_rep_wack
                                                      : tile_msg_pkg::e_rep_rdata;

  always_comb begin
    cmd_o.we   = (req_r.op == tile_msg_pkg::e_req_wr);
    cmd_o.addr = req_r.addr;
    cmd_o.data = req_r.data;
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      s_idle:  if (req_fire) state_n = s_issue;
      s_issue: state_n = (dest_r == tile_map_pkg::e_dest_err) ? s_reply : s_wait;
      s_wait:  if (resp_fire) state_n = s_reply;
      s_reply: if (rep_ready_i) state_n = s_idle;
      default: state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= s_idle;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_r  <= req_i;
      dest_r <= req_dest;
    end
    if ((state_r == s_issue) && (dest_r == tile_map_pkg::e_dest_err)) begin
      rep_r <= '{op: tile_msg_pkg::e_rep_err, addr: req_r.addr, data: '0};
    end else if (resp_fire) begin
      rep_r <= '{op: ok_op, addr: req_r.addr, data: resp_data};
    end
  end

  assign rep_o       = rep_r;
  assign rep_valid_o = (state_r == s_reply); // Held until the handshake.

endmodule

/* source/l2e_tile.sv */
`include "tile_cfg.svh"

module l2e_tile (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`TILE_DID_W-1:0]   my_did_i,

  input  tile_msg_pkg::lce_req_s   req_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,

  output tile_msg_pkg::lce_rep_s   rep_o,
  output logic                     rep_valid_o,
  input  logic                     rep_ready_i,

  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [`TILE_ADDR_W-1:0]  wb_adr_o,
  output logic [`TILE_DATA_W-1:0]  wb_dat_o,
  input  logic [`TILE_DATA_W-1:0]  wb_dat_i,
  input  logic                     wb_ack_i
);

  tile_msg_pkg::mem_cmd_s   cmd;
  logic                     cfg_cmd_valid, l2_cmd_valid;
  logic                     cfg_resp_valid, cfg_resp_yumi, l2_resp_valid, l2_resp_yumi;
  logic [`TILE_DATA_W-1:0]  cfg_resp_data, l2_resp_data;
  logic                     bus_req, bus_we, bus_done;
  logic [`TILE_ADDR_W-1:0]  bus_adr;
  logic [`TILE_DATA_W-1:0]  bus_dat, bus_rdata;

  l2e_ctrl ctrl (
    .clk_i, .rst_n_i, .req_i, .req_valid_i, .req_ready_o,
    .rep_o, .rep_valid_o, .rep_ready_i,
    .cmd_o(cmd), .cfg_cmd_valid_o(cfg_cmd_valid), .l2_cmd_valid_o(l2_cmd_valid),
    .cfg_resp_valid_i(cfg_resp_valid), .cfg_resp_data_i(cfg_resp_data),
    .cfg_resp_yumi_o(cfg_resp_yumi),
    .l2_resp_valid_i(l2_resp_valid), .l2_resp_data_i(l2_resp_data),
    .l2_resp_yumi_o(l2_resp_yumi)
  );

  cfg_regs cfg (
    .clk_i, .rst_n_i, .cmd_i(cmd), .cmd_valid_i(cfg_cmd_valid), .my_did_i,
    .resp_valid_o(cfg_resp_valid), .resp_data_o(cfg_resp_data), .resp_yumi_i(cfg_resp_yumi)
  );

  l2_slice l2s (
    .clk_i, .rst_n_i, .cmd_i(cmd), .cmd_valid_i(l2_cmd_valid),
    .resp_valid_o(l2_resp_valid), .resp_data_o(l2_resp_data), .resp_yumi_i(l2_resp_yumi),
    .bus_req_o(bus_req), .bus_we_o(bus_we), .bus_adr_o(bus_adr), .bus_dat_o(bus_dat),
    .bus_done_i(bus_done), .bus_rdata_i(bus_rdata)
  );

  wb_mem_master wbm (
    .clk_i, .rst_n_i,
    .bus_req_i(bus_req), .bus_we_i(bus_we), .bus_adr_i(bus_adr), .bus_dat_i(bus_dat),
    .bus_done_o(bus_done), .bus_rdata_o(bus_rdata),
    .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o, .wb_dat_i, .wb_ack_i
  );

endmodule

/* source/tile_cfg.svh */
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// ****************************************
// Widths
// ****************************************
`define TILE_ADDR_W     32
`define TILE_DATA_W     32
`define TILE_DID_W      8

// ****************************************
// L2 slice and register block sizes
// ****************************************
`define TILE_L2_SETS    16
`define TILE_L2_IDX_W   $clog2(`TILE_L2_SETS)
`define TILE_L2_TAG_W   (`TILE_ADDR_W - `TILE_L2_IDX_W - 2)
`define TILE_CFG_REGS   8
`define TILE_CFG_IDX_W  $clog2(`TILE_CFG_REGS)

`define TILE_DRAM_BASE  32'h8000_0000 // Everything below this is local.

`endif

/* source/tile_map_pkg.sv */
`include "tile_cfg.svh"

package tile_map_pkg;

  // Local device field, bits 23..20 of a local address.
  typedef enum logic [3:0] {
    e_dev_host  = 4'd0,
    e_dev_cfg   = 4'd1,
    e_dev_clint = 4'd2
  } dev_e;

  typedef enum logic [1:0] {
    e_dest_cfg = 2'd0,
    e_dest_l2  = 2'd1,
    e_dest_err = 2'd2
  } dest_e;

  typedef struct packed {
    logic [`TILE_ADDR_W-25:0]      hi;
    dev_e                          dev;      // Bits 23..20.
    logic [17-`TILE_CFG_IDX_W:0]   rsvd;
    logic [`TILE_CFG_IDX_W-1:0]    reg_idx;  // Bits 4..2.
    logic [1:0]                    byte_off;
  } cfg_addr_s;

  typedef struct packed {
    logic [`TILE_L2_TAG_W-1:0]  tag;
    logic [`TILE_L2_IDX_W-1:0]  idx;
    logic [1:0]                 byte_off;
  } l2_addr_s;

  // The same address word seen by the register block and by the cache.
  typedef union packed {
    cfg_addr_s cfg;
    l2_addr_s  l2;
  } mem_addr_u;

endpackage

/* source/tile_msg_pkg.sv */
`include "tile_cfg.svh"

package tile_msg_pkg;

  typedef enum logic {
    e_req_rd = 1'b0,
    e_req_wr = 1'b1
  } req_op_e;

  // ****************************************
  // Messages on the tile ports
  // ****************************************
  typedef struct packed {
    req_op_e                 op;
    logic [`TILE_ADDR_W-1:0] addr;
    logic [`TILE_DATA_W-1:0] data;
  } lce_req_s;

  typedef enum logic [1:0] {
    e_rep_rdata = 2'd0,
    e_rep_wack  = 2'd1,
    e_rep_err   = 2'd2
  } rep_op_e;

  typedef struct packed {
    rep_op_e                 op;
    logic [`TILE_ADDR_W-1:0] addr;
    logic [`TILE_DATA_W-1:0] data;
  } lce_rep_s;

  // ****************************************
  // Controller to datapath blocks
  // ****************************************
  typedef struct packed {
    logic                    we;
    tile_map_pkg::mem_addr_u addr;
    logic [`TILE_DATA_W-1:0] data;
  } mem_cmd_s;

endpackage

/* source/wb_mem_master.sv */
`include "tile_cfg.svh"

module wb_mem_master (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  input  logic                     bus_req_i,
  input  logic                     bus_we_i,
  input  logic [`TILE_ADDR_W-1:0]  bus_adr_i,
  input  logic [`TILE_DATA_W-1:0]  bus_dat_i,
  output logic                     bus_done_o,
  output logic [`TILE_DATA_W-1:0]  bus_rdata_o,

  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [`TILE_ADDR_W-1:0]  wb_adr_o,
  output logic [`TILE_DATA_W-1:0]  wb_dat_o,
  input  logic [`TILE_DATA_W-1:0]  wb_dat_i,
  input  logic                     wb_ack_i
);

  logic                     cyc_r, done_r, we_r;
  logic [`TILE_ADDR_W-1:0]  adr_r;
  logic [`TILE_DATA_W-1:0]  dat_r, rdata_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cyc_r  <= 1'b0;
      done_r <= 1'b0;
    end else begin
      done_r <= cyc_r && wb_ack_i;   // One pulse, the cycle after ack.
      if (bus_req_i) begin
        cyc_r <= 1'b1;
      end else if (wb_ack_i) begin
        cyc_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i) begin
      we_r  <= bus_we_i;
      adr_r <= bus_adr_i;
      dat_r <= bus_dat_i;
    end
    if (cyc_r && wb_ack_i) begin
      rdata_r <= wb_dat_i;
    end
  end

  assign wb_cyc_o    = cyc_r;
  assign wb_stb_o    = cyc_r;   // Classic single cycle, so stb follows cyc.
  assign wb_we_o     = we_r;
  assign wb_adr_o    = adr_r;
  assign wb_dat_o    = dat_r;
  assign bus_done_o  = done_r;
  assign bus_rdata_o = rdata_r;

endmodule

/* tb/l2e_tile_props.sv */
`include "tile_cfg.svh"

module l2e_tile_props (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     req_valid_i,
  input logic                     req_ready_i,
  input tile_msg_pkg::lce_rep_s   rep_i,
  input logic                     rep_valid_i,
  input logic                     rep_ready_i,
  input logic                     cfg_cmd_valid_i,
  input logic                     wb_cyc_i,
  input logic                     wb_stb_i,
  input logic                     wb_we_i,
  input logic [`TILE_ADDR_W-1:0]  wb_adr_i,
  input logic [`TILE_DATA_W-1:0]  wb_wdat_i,
  input logic                     wb_ack_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int    fail_cnt = 0;
  logic  busy_r;
  logic  cfg_txn_r;
  logic  rep_fire;

  assign rep_fire = rep_valid_i && rep_ready_i;

  // From acceptance to the reply handshake.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_r    <= 1'b0;
      cfg_txn_r <= 1'b0;
    end else begin
      if (req_valid_i && req_ready_i) begin
        busy_r <= 1'b1;
      end else if (rep_fire) begin
        busy_r <= 1'b0;
      end
      if (cfg_cmd_valid_i) begin
        cfg_txn_r <= 1'b1;
      end else if (rep_fire) begin
        cfg_txn_r <= 1'b0;
      end
    end
  end

  // ****************************************
  // Reply port
  // ****************************************
  reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |=> !rep_valid_i && !wb_cyc_i && !wb_stb_i && req_ready_i)
    else begin
      $error("Tile is not idle after reset.");
      fail_cnt++;
    end

  rep_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rep_valid_i && !rep_ready_i |=> rep_valid_i && $stable(rep_i))
    else begin
      $error("Reply changed while the receiver stalled.");
      fail_cnt++;
    end

  one_in_flight: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_r |-> !req_ready_i)
    else begin
      $error("Tile is ready for a request before the reply handshake.");
      fail_cnt++;
    end

  // ****************************************
  // Wishbone side
  // ****************************************
  stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_stb_i |-> wb_cyc_i)
    else begin
      $error("Wishbone stb is high without cyc.");
      fail_cnt++;
    end

  wb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i) && $stable(wb_we_i)
      && $stable(wb_wdat_i))
    else begin
      $error("Wishbone cycle changed before ack.");
      fail_cnt++;
    end

  wb_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_stb_i && wb_ack_i |=> !wb_stb_i && !wb_cyc_i)
    else begin
      $error("Wishbone cycle did not end after ack.");
      fail_cnt++;
    end

  cfg_no_bus: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_cmd_valid_i || cfg_txn_r |-> !wb_cyc_i)
    else begin
      $error("Wishbone cycle during a config access.");
      fail_cnt++;
    end

endmodule

bind l2e_tile l2e_tile_props props0 (
  .clk_i(clk_i), .rst_n_i(rst_n_i),
  .req_valid_i(req_valid_i), .req_ready_i(req_ready_o),
  .rep_i(rep_o), .rep_valid_i(rep_valid_o), .rep_ready_i(rep_ready_i),
  .cfg_cmd_valid_i(cfg_cmd_valid),
  .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o), .wb_we_i(wb_we_o),
  .wb_adr_i(wb_adr_o), .wb_wdat_i(wb_dat_o), .wb_ack_i(wb_ack_i)
);

/* tb/l2e_tile_tb.sv */
`include "tile_cfg.svh"

module l2e_tile_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [`TILE_DID_W-1:0] MY_DID   = 8'h5a;
  localparam logic [31:0]            CFG_BASE = 32'h0010_0000; // Device 1 in bits 23..20.

  logic                     clk = 1'b0;
  logic                     rst_n;
  tile_msg_pkg::lce_req_s   req;
  logic                     req_valid;
  logic                     req_ready;
  tile_msg_pkg::lce_rep_s   rep;
  logic                     rep_valid;
  logic                     rep_ready;
  logic                     wb_cyc, wb_stb, wb_we, wb_ack;
  logic [`TILE_ADDR_W-1:0]  wb_adr;
  logic [`TILE_DATA_W-1:0]  wb_wdat, wb_rdat;

  int           seed = 94;
  int           errors = 0;
  int           reqs_issued = 0;
  int           wb_cnt = 0;
  string        test_name = "reset";
  logic         last_we;
  logic [31:0]  last_adr, last_dat;
  logic [31:0]  slave_mem [logic [31:0]];
  logic [31:0]  ref_mem [logic [31:0]];
  logic [31:0]  ref_cfg [`TILE_CFG_REGS];
  logic         sh_valid [`TILE_L2_SETS];
  logic [31:0]  sh_tag [`TILE_L2_SETS];

  l2e_tile dut0 (
    .clk_i(clk), .rst_n_i(rst_n), .my_did_i(MY_DID),
    .req_i(req), .req_valid_i(req_valid), .req_ready_o(req_ready),
    .rep_o(rep), .rep_valid_o(rep_valid), .rep_ready_i(rep_ready),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_dat_o(wb_wdat), .wb_dat_i(wb_rdat), .wb_ack_i(wb_ack)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    rep_ready <= (($random(seed) & 3) != 0); // Stalls about one cycle in four.
  end

  // ****************************************
  // Wishbone slave memory
  // ****************************************
  always @(posedge clk) begin
    wb_ack <= wb_cyc && wb_stb && !wb_ack;
    if (wb_cyc && wb_stb && !wb_ack) begin
      wb_cnt   <= wb_cnt + 1;
      last_we  <= wb_we;
      last_adr <= wb_adr;
      last_dat <= wb_wdat;
      if (wb_we) begin
        slave_mem[wb_adr] = wb_wdat;
      end else begin
        wb_rdat <= slave_mem.exists(wb_adr) ? slave_mem[wb_adr] : wb_adr; // Unwritten words.
      end
    end
  end

  task automatic check_val(input string what, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    assert (exp_v === act_v) else begin
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic finish_run();
    int total;
    total = errors + dut0.props0.fail_cnt;
    $display("Summary: %0d requests, %0d check errors, %0d assertion failures",
             reqs_issued, errors, dut0.props0.fail_cnt);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // One request through the tile, checked against the reference model.
  task automatic run_req(input logic wr, input logic [31:0] addr, input logic [31:0] data);
    tile_msg_pkg::lce_rep_s  exp;
    tile_msg_pkg::lce_rep_s  got;
    int                      start_cnt;
    int                      exp_cnt;
    int                      set;
    int                      ridx;
    logic [31:0]             tag;
    logic                    hit;
    exp      = '0;
    exp.addr = addr;
    exp_cnt  = 0;
    set      = int'(addr[2 +: `TILE_L2_IDX_W]);
    tag      = addr >> (2 + `TILE_L2_IDX_W);
    ridx     = int'(addr[4:2]);
    if (addr >= `TILE_DRAM_BASE) begin
      exp.op  = wr ? tile_msg_pkg::e_rep_wack : tile_msg_pkg::e_rep_rdata;
      hit     = sh_valid[set] && (sh_tag[set] == tag);
      exp_cnt = (wr || !hit) ? 1 : 0;
      if (wr) begin
        ref_mem[addr] = data;
      end else begin
        exp.data      = ref_mem.exists(addr) ? ref_mem[addr] : addr;
        sh_valid[set] = 1'b1;
        sh_tag[set]   = tag;
      end
    end else if (addr[23:20] == 4'd1) begin
      exp.op = wr ? tile_msg_pkg::e_rep_wack : tile_msg_pkg::e_rep_rdata;
      if (!wr) begin
        exp.data = (ridx == 0) ? 32'(MY_DID) : ref_cfg[ridx];
      end else if (ridx != 0) begin
        ref_cfg[ridx] = data;
      end
    end else begin
      exp.op = tile_msg_pkg::e_rep_err;
    end
    @(posedge clk);
    req       <= '{op: tile_msg_pkg::req_op_e'(wr), addr: addr, data: data};
    req_valid <= 1'b1;
    do @(posedge clk); while (!req_ready);
    req_valid <= 1'b0;
    reqs_issued++;
    start_cnt = wb_cnt;
    do @(posedge clk); while (!(rep_valid && rep_ready));
    got = rep;
    check_val("op", 32'(exp.op), 32'(got.op));
    check_val("addr", exp.addr, got.addr);
    if (exp.op == tile_msg_pkg::e_rep_rdata) begin
      check_val("data", exp.data, got.data);
    end
    check_val("wb_cycles", 32'(exp_cnt), 32'(wb_cnt - start_cnt));
    if (exp_cnt == 1) begin
      check_val("wb_we", 32'(wr), 32'(last_we));
      check_val("wb_adr", addr, last_adr);
      if (wr) begin
        check_val("wb_dat", data, last_dat);
      end
    end
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < 400 * (reqs_issued + 1)) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: watchdog expired after %0d cycles, a request got no reply", cycles);
    errors++;
    finish_run();
  end

  initial begin
    logic [31:0] addr;
    rst_n     = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    rep_ready = 1'b0;
    wb_ack    = 1'b0;
    wb_rdat   = '0;
    for (int i = 0; i < `TILE_CFG_REGS; i++) ref_cfg[i] = '0;
    for (int i = 0; i < `TILE_L2_SETS; i++) sh_valid[i] = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "cfg_rw";
    for (int i = 1; i < `TILE_CFG_REGS; i++) begin
      run_req(1'b1, CFG_BASE + 32'(i * 4), 32'hc0de_0000 + 32'(i));
    end
    for (int i = 0; i < `TILE_CFG_REGS; i++) run_req(1'b0, CFG_BASE + 32'(i * 4), '0);
    run_req(1'b1, CFG_BASE, 32'hffff_ffff); // Register 0 stays read-only.
    run_req(1'b0, CFG_BASE, '0);

    test_name = "dram_wt";
    for (int i = 0; i < 8; i++) run_req(1'b1, `TILE_DRAM_BASE + 32'(i * 4), $random(seed));
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 8; i++) run_req(1'b0, `TILE_DRAM_BASE + 32'(i * 4), '0);
    end

    test_name = "conflict";
    run_req(1'b0, `TILE_DRAM_BASE + 32'h40, '0);
    run_req(1'b0, `TILE_DRAM_BASE, '0);
    run_req(1'b1, `TILE_DRAM_BASE, 32'h1234_5678);
    run_req(1'b0, `TILE_DRAM_BASE, '0);

    test_name = "bad_dev";
    run_req(1'b0, 32'h0000_0010, '0);
    run_req(1'b1, 32'h0020_0004, 32'hdead_beef);
    run_req(1'b0, 32'h7ff0_0000, '0);
    run_req(1'b1, 32'h0030_0008, 32'h0bad_0bad);

    test_name = "random";
    repeat (16) begin
      if (($random(seed) & 3) == 0) begin
        addr = CFG_BASE + 32'(($random(seed) & 7) * 4);
      end else begin
        addr = `TILE_DRAM_BASE + 32'(($random(seed) & 31) * 4); // Two tags per set.
      end
      run_req(1'($random(seed)), addr, $random(seed));
    end
    repeat (4) @(posedge clk);
    finish_run();
  end

endmodule
